//--- Makefile
.PHONY: all lint clean

all: obj_dir/Vmem_front_tb
	./obj_dir/Vmem_front_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

obj_dir/Vmem_front_tb: mem_front.f common/*.sv store_buffer/*.sv source/*.sv test/*.sv
	verilator --binary --timing --assert -j 0 --top-module mem_front_tb -f mem_front.f

lint:
	verilator --lint-only --timing -Wall --top-module mem_front_tb -f mem_front.f

clean:
	rm -rf obj_dir sim.log

//--- common/mem_front_pkg.sv
`default_nettype none

package mem_front_pkg;

	localparam int LINE_BYTES = 16;	// Bytes per cache line
	localparam int STRANDS = 4;	// Hardware strands per core

	typedef logic [LINE_BYTES * 8 - 1:0] line_t;	// One full cache line
	typedef logic [LINE_BYTES - 1:0] mask_t;	// Byte enables for a line
	typedef logic [31:0] word_t;	// Instruction or data word
	typedef logic [27:0] line_addr_t;	// Byte address minus line offset
	typedef logic [1:0] lane_t;	// Word index within a line
	typedef logic [1:0] strand_t;	// Strand index
	typedef logic [STRANDS - 1:0] strand_set_t;	// One bit per strand
	typedef logic [3:0] core_t;	// Core index
	typedef logic [1:0] unit_t;	// Requesting unit on the L2 bus
	typedef logic [2:0] l2_op_t;	// L2 operation code

	// Unit codes, shared by requests and responses
	localparam unit_t UNIT_ICACHE = 2'd0;
	localparam unit_t UNIT_DCACHE = 2'd1;
	localparam unit_t UNIT_STBUF = 2'd2;

	localparam l2_op_t OP_LOAD = 3'd0;	// Line fill
	localparam l2_op_t OP_STORE = 3'd1;	// Masked line write

	// Store buffer entry life cycle
	typedef enum logic [1:0]
	{
		SB_EMPTY,	// Free for a new store
		SB_ISSUE,	// Waiting for the arbiter
		SB_WAIT_ACK	// Sent, waiting for L2 response
	} sb_state_t;

endpackage

`default_nettype wire

//--- mem_front.f
common/mem_front_pkg.sv
store_buffer/store_buffer.sv
source/load_return.sv
source/l2_request_arbiter.sv
source/l2_response_router.sv
source/mem_front_top.sv
test/mem_front_chk.sv
test/mem_front_tb.sv

//--- source/l2_request_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module l2_request_arbiter
(
	input logic clk,
	input logic reset,
	input logic icache_valid_i,
	input mem_front_pkg::strand_t icache_strand_i,
	input mem_front_pkg::line_addr_t icache_addr_i,
	output logic icache_ready_o,
	input logic dcache_valid_i,
	input mem_front_pkg::strand_t dcache_strand_i,
	input mem_front_pkg::line_addr_t dcache_addr_i,
	output logic dcache_ready_o,
	input logic stbuf_valid_i,
	input mem_front_pkg::strand_t stbuf_strand_i,
	input mem_front_pkg::line_addr_t stbuf_addr_i,
	input mem_front_pkg::line_t stbuf_data_i,
	input mem_front_pkg::mask_t stbuf_mask_i,
	output logic stbuf_ready_o,
	output logic l2req_valid_o,
	input logic l2req_ready_i,
	output mem_front_pkg::unit_t l2req_unit_o,
	output mem_front_pkg::strand_t l2req_strand_o,
	output mem_front_pkg::l2_op_t l2req_op_o,
	output mem_front_pkg::line_addr_t l2req_addr_o,
	output mem_front_pkg::line_t l2req_data_o,
	output mem_front_pkg::mask_t l2req_mask_o
);
	import mem_front_pkg::*;

	logic transfer;	// L2 takes the held request
	logic slot_free;	// Output register may load
	logic [2:0] taken;	// Source finishing this cycle, by unit code
	logic [2:0] req_vec;	// Eligible requests, by unit code
	logic grant_any;
	unit_t grant_unit;
	unit_t rr_ptr;	// Unit with highest priority
	strand_t grant_strand;
	l2_op_t grant_op;
	line_addr_t grant_addr;
	line_t grant_data;
	mask_t grant_mask;

	assign transfer = l2req_valid_o && l2req_ready_i;
	assign slot_free = !l2req_valid_o || l2req_ready_i;

	// A source still shows valid in its ready cycle, so skip it once
	assign taken = transfer ? (3'b001 << l2req_unit_o) : 3'b000;
	assign req_vec = {stbuf_valid_i, dcache_valid_i, icache_valid_i} & ~taken;

	// Scan from lowest priority up, so the pointer's unit wins last
	always_comb
	begin
		int idx;
		grant_any = 1'b0;
		grant_unit = rr_ptr;
		for (int k = 2; k >= 0; k--)
		begin
			idx = (int'(rr_ptr) + k) % 3;
			if (req_vec[idx])
			begin
				grant_any = 1'b1;
				grant_unit = unit_t'(idx);
			end
		end
	end

	// Field mux, fills carry no data
	always_comb
	begin
		grant_strand = icache_strand_i;
		grant_addr = icache_addr_i;
		grant_op = OP_LOAD;
		grant_data = '0;
		grant_mask = '0;
		case (grant_unit)
			UNIT_DCACHE:
			begin
				grant_strand = dcache_strand_i;
				grant_addr = dcache_addr_i;
			end
			UNIT_STBUF:
			begin
				grant_strand = stbuf_strand_i;
				grant_addr = stbuf_addr_i;
				grant_op = OP_STORE;
				grant_data = stbuf_data_i;
				grant_mask = stbuf_mask_i;
			end
			default:
			begin
				grant_op = OP_LOAD;	// Icache fill
			end
		endcase
	end

	assign icache_ready_o = transfer && l2req_unit_o == UNIT_ICACHE;
	assign dcache_ready_o = transfer && l2req_unit_o == UNIT_DCACHE;
	assign stbuf_ready_o = transfer && l2req_unit_o == UNIT_STBUF;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			l2req_valid_o <= 1'b0;
			rr_ptr <= UNIT_ICACHE;
		end
		else
		begin
			if (transfer)	// Rotate past the winner
				rr_ptr <= (l2req_unit_o == UNIT_STBUF) ? UNIT_ICACHE : unit_t'(l2req_unit_o + 2'd1);
			if (slot_free)
				l2req_valid_o <= grant_any;
		end
	end

	// Held request, stable while ready is low
	always_ff @(posedge clk)
	begin
		if (slot_free && grant_any)
		begin
			l2req_unit_o <= grant_unit;
			l2req_strand_o <= grant_strand;
			l2req_op_o <= grant_op;
			l2req_addr_o <= grant_addr;
			l2req_data_o <= grant_data;
			l2req_mask_o <= grant_mask;
		end
	end

endmodule

`default_nettype wire

//--- source/l2_response_router.sv
`timescale 1ns/1ns
`default_nettype none

module l2_response_router
#(
	parameter mem_front_pkg::core_t CORE_ID = 4'd0
)
(
	input logic clk,
	input logic reset,
	input logic l2rsp_valid_i,
	input mem_front_pkg::core_t l2rsp_core_i,
	input mem_front_pkg::unit_t l2rsp_unit_i,
	input mem_front_pkg::strand_t l2rsp_strand_i,
	output logic store_ack_valid_o,
	output mem_front_pkg::strand_t store_ack_strand_o,
	output mem_front_pkg::strand_set_t icache_fill_done_o,
	output mem_front_pkg::strand_set_t dcache_fill_done_o
);
	import mem_front_pkg::*;

	logic rsp_mine;	// Response addressed to this core
	strand_set_t rsp_bit;	// One-hot of responding strand

	// Broadcast bus, other cores' traffic is dropped here
	assign rsp_mine = l2rsp_valid_i && l2rsp_core_i == CORE_ID;
	assign rsp_bit = strand_set_t'(1) << l2rsp_strand_i;

	// Store buffer registers this itself
	assign store_ack_valid_o = rsp_mine && l2rsp_unit_i == UNIT_STBUF;
	assign store_ack_strand_o = l2rsp_strand_i;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			icache_fill_done_o <= '0;
			dcache_fill_done_o <= '0;
		end
		else
		begin
			icache_fill_done_o <= (rsp_mine && l2rsp_unit_i == UNIT_ICACHE) ? rsp_bit : '0;
			dcache_fill_done_o <= (rsp_mine && l2rsp_unit_i == UNIT_DCACHE) ? rsp_bit : '0;
		end
	end

endmodule

`default_nettype wire

//--- source/load_return.sv
`timescale 1ns/1ns
`default_nettype none

module load_return
(
	input logic clk,
	input logic reset,
	input logic load_valid_i,
	input mem_front_pkg::lane_t load_lane_i,
	input mem_front_pkg::line_t cache_line_i,
	input mem_front_pkg::line_t fwd_data_i,
	input mem_front_pkg::mask_t fwd_mask_i,
	output mem_front_pkg::word_t load_data_o,
	output logic load_data_valid_o
);
	import mem_front_pkg::*;

	line_t merged_line;	// Cache line with pending store bytes applied
	word_t lane_word;	// Addressed word of merged line

	// Byte-wise select between store buffer and L1 data
	always_comb
	begin
		for (int b = 0; b < LINE_BYTES; b++)
		begin
			if (fwd_mask_i[b])
				merged_line[b * 8 +: 8] = fwd_data_i[b * 8 +: 8];	// Newer store byte
			else
				merged_line[b * 8 +: 8] = cache_line_i[b * 8 +: 8];
		end
	end

	assign lane_word = merged_line[load_lane_i * 32 +: 32];	// Lane 0 at the bottom

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			load_data_valid_o <= 1'b0;
		else
			load_data_valid_o <= load_valid_i;	// One cycle load latency
	end

	always_ff @(posedge clk)
	begin
		if (load_valid_i)
			load_data_o <= lane_word;
	end

endmodule

`default_nettype wire

//--- source/mem_front_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_front_top
#(
	parameter mem_front_pkg::core_t CORE_ID = 4'd0
)
(
	input logic clk,
	input logic reset,
	input logic load_valid_i,
	input mem_front_pkg::strand_t load_strand_i,
	input mem_front_pkg::line_addr_t load_addr_i,
	input mem_front_pkg::lane_t load_lane_i,
	input mem_front_pkg::line_t cache_line_i,
	output mem_front_pkg::word_t load_data_o,
	output logic load_data_valid_o,
	input logic store_valid_i,
	input mem_front_pkg::strand_t store_strand_i,
	input mem_front_pkg::line_addr_t store_addr_i,
	input mem_front_pkg::line_t store_data_i,
	input mem_front_pkg::mask_t store_mask_i,
	output logic store_accept_o,
	output logic rollback_o,
	output mem_front_pkg::strand_set_t store_resume_o,
	input logic icache_valid_i,
	input mem_front_pkg::strand_t icache_strand_i,
	input mem_front_pkg::line_addr_t icache_addr_i,
	output logic icache_ready_o,
	input logic dcache_valid_i,
	input mem_front_pkg::strand_t dcache_strand_i,
	input mem_front_pkg::line_addr_t dcache_addr_i,
	output logic dcache_ready_o,
	output logic l2req_valid_o,
	input logic l2req_ready_i,
	output mem_front_pkg::unit_t l2req_unit_o,
	output mem_front_pkg::strand_t l2req_strand_o,
	output mem_front_pkg::l2_op_t l2req_op_o,
	output mem_front_pkg::line_addr_t l2req_addr_o,
	output mem_front_pkg::line_t l2req_data_o,
	output mem_front_pkg::mask_t l2req_mask_o,
	input logic l2rsp_valid_i,
	input mem_front_pkg::core_t l2rsp_core_i,
	input mem_front_pkg::unit_t l2rsp_unit_i,
	input mem_front_pkg::strand_t l2rsp_strand_i,
	output mem_front_pkg::strand_set_t icache_fill_done_o,
	output mem_front_pkg::strand_set_t dcache_fill_done_o
);
	import mem_front_pkg::*;

	logic stbuf_valid;	// Store buffer to arbiter
	logic stbuf_ready;
	strand_t stbuf_strand;
	line_addr_t stbuf_addr;
	line_t stbuf_data;
	mask_t stbuf_mask;
	line_t fwd_data;	// Store-to-load forwarding
	mask_t fwd_mask;
	logic store_ack_valid;	// Router to store buffer
	strand_t store_ack_strand;

	store_buffer i_store_buffer (.clk(clk), .reset(reset),
		.store_valid_i(store_valid_i), .store_strand_i(store_strand_i),
		.store_addr_i(store_addr_i), .store_data_i(store_data_i), .store_mask_i(store_mask_i),
		.load_strand_i(load_strand_i), .load_addr_i(load_addr_i),
		.fwd_data_o(fwd_data), .fwd_mask_o(fwd_mask),
		.store_accept_o(store_accept_o), .rollback_o(rollback_o),
		.l2req_valid_o(stbuf_valid), .l2req_ready_i(stbuf_ready),
		.l2req_strand_o(stbuf_strand), .l2req_addr_o(stbuf_addr),
		.l2req_data_o(stbuf_data), .l2req_mask_o(stbuf_mask),
		.ack_valid_i(store_ack_valid), .ack_strand_i(store_ack_strand),
		.store_resume_o(store_resume_o));

	load_return i_load_return (.clk(clk), .reset(reset), .load_valid_i(load_valid_i),
		.load_lane_i(load_lane_i), .cache_line_i(cache_line_i),
		.fwd_data_i(fwd_data), .fwd_mask_i(fwd_mask),
		.load_data_o(load_data_o), .load_data_valid_o(load_data_valid_o));

	l2_request_arbiter i_l2_request_arbiter (.clk(clk), .reset(reset),
		.icache_valid_i(icache_valid_i), .icache_strand_i(icache_strand_i),
		.icache_addr_i(icache_addr_i), .icache_ready_o(icache_ready_o),
		.dcache_valid_i(dcache_valid_i), .dcache_strand_i(dcache_strand_i),
		.dcache_addr_i(dcache_addr_i), .dcache_ready_o(dcache_ready_o),
		.stbuf_valid_i(stbuf_valid), .stbuf_strand_i(stbuf_strand),
		.stbuf_addr_i(stbuf_addr), .stbuf_data_i(stbuf_data),
		.stbuf_mask_i(stbuf_mask), .stbuf_ready_o(stbuf_ready),
		.l2req_valid_o(l2req_valid_o), .l2req_ready_i(l2req_ready_i),
		.l2req_unit_o(l2req_unit_o), .l2req_strand_o(l2req_strand_o),
		.l2req_op_o(l2req_op_o), .l2req_addr_o(l2req_addr_o),
		.l2req_data_o(l2req_data_o), .l2req_mask_o(l2req_mask_o));

	l2_response_router #(.CORE_ID(CORE_ID)) i_l2_response_router (.clk(clk), .reset(reset),
		.l2rsp_valid_i(l2rsp_valid_i), .l2rsp_core_i(l2rsp_core_i),
		.l2rsp_unit_i(l2rsp_unit_i), .l2rsp_strand_i(l2rsp_strand_i),
		.store_ack_valid_o(store_ack_valid), .store_ack_strand_o(store_ack_strand),
		.icache_fill_done_o(icache_fill_done_o), .dcache_fill_done_o(dcache_fill_done_o));

endmodule

`default_nettype wire

//--- store_buffer/store_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module store_buffer
(
	input logic clk,
	input logic reset,
	input logic store_valid_i,
	input mem_front_pkg::strand_t store_strand_i,
	input mem_front_pkg::line_addr_t store_addr_i,
	input mem_front_pkg::line_t store_data_i,
	input mem_front_pkg::mask_t store_mask_i,
	input mem_front_pkg::strand_t load_strand_i,
	input mem_front_pkg::line_addr_t load_addr_i,
	output mem_front_pkg::line_t fwd_data_o,
	output mem_front_pkg::mask_t fwd_mask_o,
	output logic store_accept_o,
	output logic rollback_o,
	output logic l2req_valid_o,
	input logic l2req_ready_i,
	output mem_front_pkg::strand_t l2req_strand_o,
	output mem_front_pkg::line_addr_t l2req_addr_o,
	output mem_front_pkg::line_t l2req_data_o,
	output mem_front_pkg::mask_t l2req_mask_o,
	input logic ack_valid_i,
	input mem_front_pkg::strand_t ack_strand_i,
	output mem_front_pkg::strand_set_t store_resume_o
);
	import mem_front_pkg::*;

	sb_state_t entry_state [STRANDS];	// Per-strand state
	line_addr_t entry_addr [STRANDS];
	line_t entry_data [STRANDS];
	mask_t entry_mask [STRANDS];
	logic offer_active;	// Entry already offered, hold selection
	strand_t offer_strand;	// Strand held until ready
	logic issue_any;	// Some entry waits for the arbiter
	strand_t issue_low;	// Lowest strand in SB_ISSUE
	strand_t sel_strand;	// Entry driving the request fields
	logic store_ok;	// Target entry is free

	assign store_ok = (entry_state[store_strand_i] == SB_EMPTY);

	// Priority pick, lowest strand wins
	always_comb
	begin
		issue_any = 1'b0;
		issue_low = '0;
		for (int i = STRANDS - 1; i >= 0; i--)
		begin
			if (entry_state[i] == SB_ISSUE)
			begin
				issue_any = 1'b1;
				issue_low = strand_t'(i);
			end
		end
	end

	// The arbiter copies the fields at grant time, so the offered entry
	// must not change until the L2 takes it, even if a lower strand fills
	assign sel_strand = offer_active ? offer_strand : issue_low;
	assign l2req_valid_o = offer_active || issue_any;
	assign l2req_strand_o = sel_strand;
	assign l2req_addr_o = entry_addr[sel_strand];
	assign l2req_data_o = entry_data[sel_strand];
	assign l2req_mask_o = entry_mask[sel_strand];

	// Forward only a live entry of the same strand and line
	assign fwd_data_o = entry_data[load_strand_i];
	assign fwd_mask_o = (entry_state[load_strand_i] != SB_EMPTY
		&& entry_addr[load_strand_i] == load_addr_i) ? entry_mask[load_strand_i] : '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < STRANDS; i++)
				entry_state[i] <= SB_EMPTY;
			offer_active <= 1'b0;
			offer_strand <= '0;
			store_accept_o <= 1'b0;
			rollback_o <= 1'b0;
			store_resume_o <= '0;
		end
		else
		begin
			for (int i = 0; i < STRANDS; i++)
			begin
				if (store_valid_i && store_strand_i == strand_t'(i) && store_ok)
					entry_state[i] <= SB_ISSUE;	// New store captured
				else if (l2req_valid_o && l2req_ready_i && sel_strand == strand_t'(i))
					entry_state[i] <= SB_WAIT_ACK;	// Taken by L2
				else if (ack_valid_i && ack_strand_i == strand_t'(i))
					entry_state[i] <= SB_EMPTY;	// L2 done, free again
			end

			if (l2req_ready_i)
				offer_active <= 1'b0;	// Transfer done
			else if (l2req_valid_o)
			begin
				offer_active <= 1'b1;	// Lock current pick
				offer_strand <= sel_strand;
			end

			store_accept_o <= store_valid_i && store_ok;
			rollback_o <= store_valid_i && !store_ok;	// Strand must retry later
			store_resume_o <= ack_valid_i ? strand_set_t'(1) << ack_strand_i : '0;
		end
	end

	// Entry payload, written on accept only
	always_ff @(posedge clk)
	begin
		if (store_valid_i && store_ok)
		begin
			entry_addr[store_strand_i] <= store_addr_i;
			entry_data[store_strand_i] <= store_data_i;
			entry_mask[store_strand_i] <= store_mask_i;
		end
	end

endmodule

`default_nettype wire

//--- test/mem_front_chk.sv
`timescale 1ns/1ns
`default_nettype none

module mem_front_chk
#(
	parameter int FIELD_W = 8
)
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input logic req_ready,
	input logic [FIELD_W - 1:0] req_fields,	// All request fields packed
	input logic accept,
	input logic rollback,
	input mem_front_pkg::strand_set_t resume
);
	import mem_front_pkg::*;

	// Offered request waits unchanged until taken
	assert property (@(posedge clk) disable iff (reset)
		req_valid && !req_ready |=> req_valid && $stable(req_fields))
		else $error("request dropped or changed while ready was low");

	assert property (@(posedge clk) disable iff (reset) !(accept && rollback))
		else $error("store accepted and rolled back in the same cycle");

	assert property (@(posedge clk) disable iff (reset) $onehot0(resume))
		else $error("store resume with more than one strand");

endmodule

bind store_buffer mem_front_chk #(.FIELD_W(174)) i_chk (.clk(clk), .reset(reset),
	.req_valid(l2req_valid_o), .req_ready(l2req_ready_i),
	.req_fields({l2req_strand_o, l2req_addr_o, l2req_data_o, l2req_mask_o}),
	.accept(store_accept_o), .rollback(rollback_o), .resume(store_resume_o));

bind l2_request_arbiter mem_front_chk #(.FIELD_W(179)) i_chk (.clk(clk), .reset(reset),
	.req_valid(l2req_valid_o), .req_ready(l2req_ready_i),
	.req_fields({l2req_unit_o, l2req_strand_o, l2req_op_o, l2req_addr_o, l2req_data_o,
		l2req_mask_o}),
	.accept(1'b0), .rollback(1'b0), .resume(4'b0000));

`default_nettype wire

//--- test/mem_front_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_front_tb;
	import mem_front_pkg::*;

	localparam core_t CORE_ID = 4'd3;
	localparam int LIMIT = 2000;	// 400 operations, 5 cycles each

	logic clk, reset;
	logic load_valid_i, store_valid_i, icache_valid_i, dcache_valid_i;
	strand_t load_strand_i, store_strand_i, icache_strand_i, dcache_strand_i, l2rsp_strand_i;
	line_addr_t load_addr_i, store_addr_i, icache_addr_i, dcache_addr_i;
	lane_t load_lane_i;
	line_t cache_line_i, store_data_i;
	mask_t store_mask_i;
	logic l2req_ready_i, l2rsp_valid_i;
	core_t l2rsp_core_i;
	unit_t l2rsp_unit_i;
	word_t load_data_o;
	logic load_data_valid_o, store_accept_o, rollback_o, icache_ready_o, dcache_ready_o;
	strand_set_t store_resume_o, icache_fill_done_o, dcache_fill_done_o;
	logic l2req_valid_o;
	unit_t l2req_unit_o;
	strand_t l2req_strand_o;
	l2_op_t l2req_op_o;
	line_addr_t l2req_addr_o;
	line_t l2req_data_o;
	mask_t l2req_mask_o;

	mem_front_top #(.CORE_ID(CORE_ID)) i_dut (.*);

	int cycles = 0;
	int mism = 0;	// Wrong values
	int other = 0;	// Protocol and sequence failures
	logic hold_ready = 1'b0;	// Force L2 ready low
	logic rec_arb = 1'b0;	// Record transfer units
	unit_t arb_units [$];
	int rsp_due [$];	// L2 model pending responses
	unit_t rsp_unit [$];
	strand_t rsp_strand [$];
	int found;
	logic busy [STRANDS] = '{default: 1'b0};	// Reference entries
	line_addr_t ent_addr [STRANDS];
	line_t ent_data [STRANDS];
	mask_t ent_mask [STRANDS];
	logic pend [STRANDS] = '{default: 1'b0};	// Accepted, not yet sent to L2
	logic exp_load_v = 1'b0, exp_accept = 1'b0, exp_rollback = 1'b0;
	word_t exp_word;
	strand_set_t exp_resume = '0, exp_idone = '0, exp_ddone = '0;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic line_t rand_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// Store bytes of a live same-line entry win over the cache
	function automatic word_t ref_word(line_t cl, lane_t lane, strand_t s, line_addr_t a);
		line_t m;
		for (int b = 0; b < LINE_BYTES; b++)
			m[b * 8 +: 8] = (busy[s] && ent_addr[s] == a && ent_mask[s][b])
				? ent_data[s][b * 8 +: 8] : cl[b * 8 +: 8];
		return m[lane * 32 +: 32];
	endfunction

	function automatic strand_set_t ref_done(unit_t want);
		if (l2rsp_valid_i && l2rsp_core_i == CORE_ID && l2rsp_unit_i == want)
			return strand_set_t'(1) << l2rsp_strand_i;
		return '0;
	endfunction

	function automatic logic pending();
		logic p;
		p = icache_valid_i || dcache_valid_i || l2req_valid_o || rsp_due.size() != 0;
		for (int s = 0; s < STRANDS; s++)
			p = p || busy[s] || pend[s];
		return p;
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp)
		begin
			mism++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_strand_set(string name, strand_set_t got, strand_set_t exp);
		if (got !== exp)
		begin
			mism++;
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp)
		begin
			mism++;
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_request(string name, line_addr_t ga, line_addr_t ea, line_t gd,
		line_t ed, mask_t gm, mask_t em);
		if (ga !== ea || gd !== ed || gm !== em)
		begin
			mism++;
			$display("mismatch at %0t: %s got %h/%h/%h expected %h/%h/%h", $time, name,
				ga, gd, gm, ea, ed, em);
		end
	endtask

	// Fill requesters, drop valid only after the ready cycle
	task automatic step_fills(input logic allow_new);
		if (icache_valid_i && icache_ready_o)
			icache_valid_i <= 1'b0;
		else if (!icache_valid_i && allow_new && $urandom % 8 == 0)
		begin
			icache_valid_i <= 1'b1;
			icache_strand_i <= strand_t'($urandom);
			icache_addr_i <= line_addr_t'($urandom);
		end
		if (dcache_valid_i && dcache_ready_o)
			dcache_valid_i <= 1'b0;
		else if (!dcache_valid_i && allow_new && $urandom % 8 == 0)
		begin
			dcache_valid_i <= 1'b1;
			dcache_strand_i <= strand_t'($urandom);
			dcache_addr_i <= line_addr_t'($urandom);
		end
	endtask

	// Idle state is judged mid-cycle, once the model has caught up
	task automatic drain();
		@(posedge clk);
		load_valid_i <= 1'b0;
		store_valid_i <= 1'b0;
		step_fills(1'b0);
		@(negedge clk);
		while (pending())
		begin
			@(posedge clk);
			step_fills(1'b0);
			@(negedge clk);
		end
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("errors: %0d mismatches, %0d other failures", mism, other);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// L2 model, random ready, answers 1 to 4 cycles after each transfer
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (l2req_valid_o && l2req_ready_i)
			begin
				rsp_due.push_back(cycles + 1 + int'($urandom % 4));
				rsp_unit.push_back(l2req_unit_o);
				rsp_strand.push_back(l2req_strand_o);
			end
			l2req_ready_i <= hold_ready ? 1'b0 : ($urandom % 3 != 0);
			found = -1;
			foreach (rsp_due[i])
				if (found < 0 && rsp_due[i] <= cycles)
					found = i;
			if (found >= 0)
			begin
				l2rsp_valid_i <= 1'b1;
				l2rsp_core_i <= CORE_ID;
				l2rsp_unit_i <= rsp_unit[found];
				l2rsp_strand_i <= rsp_strand[found];
				rsp_due.delete(found);
				rsp_unit.delete(found);
				rsp_strand.delete(found);
			end
			else if ($urandom % 8 == 0)
			begin
				l2rsp_valid_i <= 1'b1;	// Traffic for another core
				l2rsp_core_i <= 4'd5;
				l2rsp_unit_i <= unit_t'($urandom % 3);
				l2rsp_strand_i <= strand_t'($urandom);
			end
			else
				l2rsp_valid_i <= 1'b0;
		end
	end

	// Compare outputs against last cycle's prediction, then predict again
	always @(posedge clk)
	begin
		if (!reset)
		begin
			check_flag("load_data_valid_o", load_data_valid_o, exp_load_v);
			if (exp_load_v)
				check_word("load_data_o", load_data_o, exp_word);
			check_flag("store_accept_o", store_accept_o, exp_accept);
			check_flag("rollback_o", rollback_o, exp_rollback);
			check_strand_set("store_resume_o", store_resume_o, exp_resume);
			check_strand_set("icache_fill_done_o", icache_fill_done_o, exp_idone);
			check_strand_set("dcache_fill_done_o", dcache_fill_done_o, exp_ddone);
			// Fill ready only in the cycle the L2 takes that unit's request
			check_flag("icache_ready_o", icache_ready_o,
				l2req_valid_o && l2req_ready_i && l2req_unit_o == UNIT_ICACHE);
			check_flag("dcache_ready_o", dcache_ready_o,
				l2req_valid_o && l2req_ready_i && l2req_unit_o == UNIT_DCACHE);
			if (l2req_valid_o && l2req_ready_i)
			begin
				if (rec_arb)
					arb_units.push_back(l2req_unit_o);
				if (l2req_unit_o == UNIT_STBUF)
				begin
					if (l2req_op_o !== OP_STORE || !pend[l2req_strand_o])
					begin
						other++;
						$display("store request at %0t has wrong op or no accepted store",
							$time);
					end
					else
						check_request("l2req store", l2req_addr_o, ent_addr[l2req_strand_o],
							l2req_data_o, ent_data[l2req_strand_o], l2req_mask_o,
							ent_mask[l2req_strand_o]);
					pend[l2req_strand_o] = 1'b0;
				end
				else if (l2req_unit_o == UNIT_ICACHE || l2req_unit_o == UNIT_DCACHE)
				begin
					// Requester holds valid through its ready cycle
					if (((l2req_unit_o == UNIT_ICACHE) ? icache_valid_i : dcache_valid_i)
						!== 1'b1)
					begin
						other++;
						$display("fill request at %0t with no fill requester waiting", $time);
					end
					if (l2req_op_o !== OP_LOAD || l2req_strand_o !== ((l2req_unit_o ==
						UNIT_ICACHE) ? icache_strand_i : dcache_strand_i))
					begin
						other++;
						$display("fill request at %0t has wrong op or strand", $time);
					end
					check_request("l2req fill", l2req_addr_o, (l2req_unit_o == UNIT_ICACHE)
						? icache_addr_i : dcache_addr_i, l2req_data_o, '0, l2req_mask_o, '0);
				end
				else
				begin
					other++;
					$display("request at %0t carries an unknown unit code", $time);
				end
			end
			exp_load_v = load_valid_i;
			exp_word = ref_word(cache_line_i, load_lane_i, load_strand_i, load_addr_i);
			exp_accept = store_valid_i && !busy[store_strand_i];
			exp_rollback = store_valid_i && busy[store_strand_i];
			exp_resume = ref_done(UNIT_STBUF);
			exp_idone = ref_done(UNIT_ICACHE);
			exp_ddone = ref_done(UNIT_DCACHE);
			if (exp_accept)
			begin
				busy[store_strand_i] = 1'b1;	// New pending entry
				pend[store_strand_i] = 1'b1;
				ent_addr[store_strand_i] = store_addr_i;
				ent_data[store_strand_i] = store_data_i;
				ent_mask[store_strand_i] = store_mask_i;
			end
			if (exp_resume != '0)
				busy[l2rsp_strand_i] = 1'b0;	// Store completed by L2
		end
	end

	initial
	begin
		void'($urandom(92));
		reset = 1'b1;
		{load_valid_i, store_valid_i, icache_valid_i, dcache_valid_i} = '0;
		{load_strand_i, store_strand_i, icache_strand_i, dcache_strand_i} = '0;
		{load_addr_i, store_addr_i, icache_addr_i, dcache_addr_i} = '0;
		load_lane_i = '0;
		cache_line_i = '0;
		store_data_i = '0;
		store_mask_i = '0;
		l2req_ready_i = 1'b0;
		l2rsp_valid_i = 1'b0;
		l2rsp_core_i = '0;
		l2rsp_unit_i = '0;
		l2rsp_strand_i = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (300)	// Mixed random traffic on two lines
		begin
			@(posedge clk);
			load_valid_i <= ($urandom % 4 != 0);
			load_strand_i <= strand_t'($urandom);
			load_addr_i <= 28'h100 + line_addr_t'($urandom % 2);
			load_lane_i <= lane_t'($urandom);
			cache_line_i <= rand_line();
			store_valid_i <= ($urandom % 4 == 0);
			store_strand_i <= strand_t'($urandom);
			store_addr_i <= 28'h100 + line_addr_t'($urandom % 2);
			store_data_i <= rand_line();
			store_mask_i <= mask_t'($urandom);
			step_fills(1'b1);
		end
		drain();
		hold_ready <= 1'b1;	// Build up a three-way contention
		repeat (2) @(posedge clk);
		store_valid_i <= 1'b1;
		store_strand_i <= 2'd1;
		store_addr_i <= 28'h2a0;
		store_data_i <= rand_line();
		store_mask_i <= 16'h0ff0;
		icache_valid_i <= 1'b1;
		icache_strand_i <= 2'd2;
		icache_addr_i <= 28'h0c40;
		dcache_valid_i <= 1'b1;
		dcache_strand_i <= 2'd3;
		dcache_addr_i <= 28'h0d80;
		@(posedge clk);
		store_valid_i <= 1'b0;
		repeat (3) @(posedge clk);
		rec_arb <= 1'b1;
		hold_ready <= 1'b0;
		while (arb_units.size() < 3)
		begin
			@(posedge clk);
			step_fills(1'b0);
			@(negedge clk);
		end
		rec_arb <= 1'b0;
		if (arb_units[0] == arb_units[1] || arb_units[1] == arb_units[2]
			|| arb_units[0] == arb_units[2])
		begin
			other++;
			$display("three transfers after contention did not cover each unit once");
		end
		drain();
		repeat (3) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", mism, other);
		if (mism == 0 && other == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
